// File: include/memCtrl_macros.svh
// RAM geometry, timing and fill macros, included by every file that sizes or models the RAM
`ifndef MEMCTRL_MACROS_SVH
`define MEMCTRL_MACROS_SVH

// number of 32-bit words in the RAM
// keep this a power of two so the word index covers it exactly
`define RAM_WORDS 256

// busy cycles ahead of the single access cycle
// any value of 1 or more works
`define RAM_LAT 2

// initial contents pattern
// word i starts out as i ^ RAM_FILL
`define RAM_FILL 32'hA5A5_0000

// width of the word index into the array
// byte address bits [RAM_AW+1:2] select the word
`define RAM_AW ($clog2(`RAM_WORDS))

`endif

// File: logic/cpuTypesPkg.sv
// word and RAM status types shared by the memory system RTL and its testbench, import where used
`default_nettype none

package cpuTypesPkg;

  // one data or byte address word
  // addresses are byte addresses, words sit on 4-byte boundaries
  typedef logic [31:0] word_t;

  // RAM progress as reported to the controller
  // the sequence for one access is BUSY for RAM_LAT cycles,
  // then ACCESS or ERROR for one cycle, then a FREE rest cycle
  typedef enum logic [1:0] {
    // no enable high, or the rest cycle after a completion
    FREE   = 2'b00,
    // latency countdown, also shown on a restart
    BUSY   = 2'b01,
    // load valid, a write commits at the end of this cycle
    ACCESS = 2'b10,
    // address out of range or not word aligned
    ERROR  = 2'b11
  } ramstate_t;

endpackage

`default_nettype wire

// File: logic/ramModel.sv
// word-wide behavioral RAM with fixed latency and a status output, driven by memoryControl
`timescale 1ns/10ps
`default_nettype none

`include "memCtrl_macros.svh"

module ramModel import cpuTypesPkg::*; (
  input  wire            CLK,
  input  wire            rst,
  input  wire            ramREN,
  input  wire            ramWEN,
  input  wire word_t     ramaddr,
  input  wire word_t     ramstore,
  output word_t          ramload,
  output ramstate_t      ramstate
);

  // counter wide enough to hold RAM_LAT-1
  localparam int LAT_W = $clog2(`RAM_LAT + 1);

  // storage
  word_t mem [`RAM_WORDS];

  // registered sequence state
  ramstate_t stateReg;
  // set for the one FREE cycle after a completion
  logic restReg;
  // busy cycles still to go after the current one
  logic [LAT_W-1:0] latCnt;
  logic [LAT_W-1:0] busyLeft;

  // request captured when an access starts
  word_t capAddr;
  logic capWen;
  logic [`RAM_AW-1:0] capIdx;

  logic req;
  logic changed;
  logic startAcc;
  logic addrBad;

  // power-up contents, not touched by reset
  initial begin
    for (int i = 0; i < `RAM_WORDS; i++) begin
      mem[i] = word_t'(i) ^ `RAM_FILL;
    end
  end

  assign req = ramREN | ramWEN;

  // a new address or operation mid-access forces a restart
  assign changed = (stateReg != FREE) &&
                   ((ramaddr != capAddr) || (ramWEN != capWen));

  // misaligned, or past the last word
  assign addrBad = (ramaddr[1:0] != 2'b00) ||
                   ((ramaddr >> 2) >= word_t'(`RAM_WORDS));

  // read port works off the captured index
  assign capIdx  = capAddr[`RAM_AW+1:2];
  assign ramload = mem[capIdx];

  // visible status
  // first busy cycle shows as soon as an enable rises on an idle RAM
  always_comb begin
    if (!req) begin
      ramstate = FREE;
    end else if (stateReg == FREE) begin
      ramstate = restReg ? FREE : BUSY;
    end else if (changed) begin
      ramstate = BUSY;
    end else begin
      ramstate = stateReg;
    end
  end

  // start of a fresh countdown, from idle or on a restart
  assign startAcc = (ramstate == BUSY) && ((stateReg == FREE) || changed);
  assign busyLeft = startAcc ? LAT_W'(`RAM_LAT - 1) : latCnt;

  // sequence control
  always_ff @(posedge CLK) begin
    if (rst) begin
      stateReg <= FREE;
      restReg  <= 1'b0;
      latCnt   <= '0;
    end else begin
      case (ramstate)
        BUSY: begin
          restReg <= 1'b0;
          // last busy cycle, pick the outcome from the live address
          if (busyLeft == '0) begin
            stateReg <= addrBad ? ERROR : ACCESS;
          end else begin
            stateReg <= BUSY;
            latCnt   <= busyLeft - 1'b1;
          end
        end
        ACCESS, ERROR: begin
          // one rest cycle so a held request cannot complete twice
          stateReg <= FREE;
          restReg  <= 1'b1;
        end
        default: begin
          stateReg <= FREE;
          restReg  <= 1'b0;
        end
      endcase
    end
  end

  // capture on every start, restarts included
  always_ff @(posedge CLK) begin
    if (startAcc) begin
      capAddr <= ramaddr;
      capWen  <= ramWEN;
    end
  end

  // write commits at the end of the access cycle
  always @(posedge CLK) begin
    if ((ramstate == ACCESS) && capWen) begin
      mem[capIdx] <= ramstore;
    end
  end

  // completions are single cycle and always followed by the rest cycle
  finalThenFree: assert property (@(posedge CLK) disable iff (rst)
    (ramstate inside {ACCESS, ERROR}) |=> (ramstate == FREE))
    else $error("ramModel: completion state not followed by FREE");

  // access only comes out of a busy countdown with the request still up
  accessFromBusy: assert property (@(posedge CLK) disable iff (rst)
    (ramstate == ACCESS) |-> (req && $past(ramstate == BUSY)))
    else $error("ramModel: ACCESS reached without a held enable");

endmodule

`default_nettype wire

// File: logic/memoryControl.sv
// fixed-priority arbiter routing instruction and data requests onto the shared RAM
`timescale 1ns/10ps
`default_nettype none

module memoryControl import cpuTypesPkg::*; (
  // sampling clock and reset for the checks only
  input  wire            CLK,
  input  wire            rst,
  // instruction port
  input  wire            iREN,
  input  wire word_t     iaddr,
  output logic           iwait,
  output word_t          iload,
  output logic           iFault,
  // data port
  input  wire            dREN,
  input  wire            dWEN,
  input  wire word_t     daddr,
  input  wire word_t     dstore,
  output logic           dwait,
  output word_t          dload,
  output logic           dFault,
  // RAM side
  input  wire word_t     ramload,
  input  wire ramstate_t ramstate,
  output logic           ramREN,
  output logic           ramWEN,
  output word_t          ramaddr,
  output word_t          ramstore
);

  // data port owns the RAM whenever it asks
  logic dataSel;
  // instruction port only gets the leftovers
  logic instSel;
  // the RAM finished the current request, good or bad
  logic done;
  // the finished request was faulty
  logic fault;

  assign dataSel = dREN | dWEN;
  assign instSel = iREN & ~dataSel;

  assign done  = (ramstate == ACCESS) || (ramstate == ERROR);
  assign fault = (ramstate == ERROR);

  // request routing
  // write beats read, data beats instruction
  always_comb begin
    ramWEN   = 1'b0;
    ramREN   = 1'b0;
    ramaddr  = '0;
    ramstore = '0;
    if (dWEN) begin
      ramWEN   = 1'b1;
      ramaddr  = daddr;
      ramstore = dstore;
    end else if (dREN) begin
      ramREN   = 1'b1;
      ramaddr  = daddr;
    end else if (iREN) begin
      ramREN   = 1'b1;
      ramaddr  = iaddr;
    end
  end

  // handshake back to the requestors
  // only the winner sees its wait drop
  always_comb begin
    dwait  = 1'b1;
    iwait  = 1'b1;
    dFault = 1'b0;
    iFault = 1'b0;
    if (dataSel) begin
      dwait  = ~done;
      dFault = fault;
    end else if (instSel) begin
      iwait  = ~done;
      iFault = fault;
    end
  end

  // both ports see the RAM read data
  // only meaningful while the matching wait is low
  assign iload = ramload;
  assign dload = ramload;

  // one completion at a time on the shared RAM
  singleRelease: assert property (@(posedge CLK) disable iff (rst)
    !(!iwait && !dwait))
    else $error("memoryControl: iwait and dwait low together");

  // a fault is only ever reported together with a completion
  iFaultWithDone: assert property (@(posedge CLK) disable iff (rst)
    $rose(iFault) |-> !iwait)
    else $error("memoryControl: iFault rose while iwait high");

  dFaultWithDone: assert property (@(posedge CLK) disable iff (rst)
    $rose(dFault) |-> !dwait)
    else $error("memoryControl: dFault rose while dwait high");

  // the data requestor never asks for both operations
  dataOneOp: assert property (@(posedge CLK) disable iff (rst)
    !(dREN && dWEN))
    else $error("memoryControl: dREN and dWEN both high");

endmodule

`default_nettype wire

// File: logic/memorySystem.sv
// memory system top, instruction and data requestor ports in front of one shared RAM
`timescale 1ns/10ps
`default_nettype none

module memorySystem import cpuTypesPkg::*; (
  input  wire        CLK,
  input  wire        rst,
  // instruction port
  input  wire        iREN,
  input  wire word_t iaddr,
  output logic       iwait,
  output word_t      iload,
  output logic       iFault,
  // data port
  input  wire        dREN,
  input  wire        dWEN,
  input  wire word_t daddr,
  input  wire word_t dstore,
  output logic       dwait,
  output word_t      dload,
  output logic       dFault
);

  // internal RAM bus
  logic      ramREN;
  logic      ramWEN;
  word_t     ramaddr;
  word_t     ramstore;
  word_t     ramload;
  ramstate_t ramstate;

  // arbiter, no state of its own
  memoryControl memoryControl_i (
    .CLK      (CLK),
    .rst      (rst),
    .iREN     (iREN),
    .iaddr    (iaddr),
    .iwait    (iwait),
    .iload    (iload),
    .iFault   (iFault),
    .dREN     (dREN),
    .dWEN     (dWEN),
    .daddr    (daddr),
    .dstore   (dstore),
    .dwait    (dwait),
    .dload    (dload),
    .dFault   (dFault),
    .ramload  (ramload),
    .ramstate (ramstate),
    .ramREN   (ramREN),
    .ramWEN   (ramWEN),
    .ramaddr  (ramaddr),
    .ramstore (ramstore)
  );

  // shared word RAM
  ramModel ramModel_i (
    .CLK      (CLK),
    .rst      (rst),
    .ramREN   (ramREN),
    .ramWEN   (ramWEN),
    .ramaddr  (ramaddr),
    .ramstore (ramstore),
    .ramload  (ramload),
    .ramstate (ramstate)
  );

endmodule

`default_nettype wire

// File: verif/memorySystemChecker.sv
// testbench monitor on the memory system ports, checks completions against a reference RAM
`timescale 1ns/10ps
`default_nettype none

`include "memCtrl_macros.svh"

module memorySystemChecker import cpuTypesPkg::*; (
  input  wire        CLK,
  input  wire        rst,
  input  wire        iREN,
  input  wire word_t iaddr,
  input  wire        iwait,
  input  wire word_t iload,
  input  wire        iFault,
  input  wire        dREN,
  input  wire        dWEN,
  input  wire word_t daddr,
  input  wire word_t dstore,
  input  wire        dwait,
  input  wire word_t dload,
  input  wire        dFault,
  output int         dataErrors,
  output int         instErrors,
  output int         protoErrors,
  output int         dataDone,
  output int         instDone
);

  // reference copy of the RAM contents
  word_t model [`RAM_WORDS];

  int cyc;
  // edge of the most recent completion on either port
  int lastDone;
  int dataStart;
  int instStart;
  logic dataActive;
  logic instActive;
  // request started on an idle RAM with no competition
  logic dataTimed;
  logic instTimed;
  logic dReq;

  // word aligned and inside the RAM, or else a fault
  function automatic logic badAddress(input word_t a);
    return ((a & 32'h3) != 32'h0) || (a >= 32'(4 * `RAM_WORDS));
  endfunction

  initial begin
    for (int i = 0; i < `RAM_WORDS; i++) begin
      model[i] = 32'(i) ^ `RAM_FILL;
    end
    cyc = 0;
    lastDone = -10;
    dataActive = 1'b0;
    instActive = 1'b0;
    dataTimed = 1'b0;
    instTimed = 1'b0;
    dataErrors = 0;
    instErrors = 0;
    protoErrors = 0;
    dataDone = 0;
    instDone = 0;
  end

  // data completion, writes update the model
  task automatic finishData;
    logic expFault;
    int idx;
    int took;
    if (!dReq) begin
      $display("data wait dropped with no data request at cycle %0d", cyc);
      protoErrors++;
      return;
    end
    expFault = badAddress(daddr);
    idx = int'(daddr >> 2);
    took = cyc - dataStart + 1;
    if (dFault !== expFault) begin
      $display("FAILED dFault at 0x%08h: expected 0x%0h, actual 0x%0h", daddr, expFault, dFault);
      dataErrors++;
    end else if (!expFault && dWEN) begin
      model[idx] = dstore;
    end else if (!expFault && (dload !== model[idx])) begin
      $display("FAILED dload at 0x%08h: expected 0x%08h, actual 0x%08h",
               daddr, model[idx], dload);
      dataErrors++;
    end
    if (dataTimed && (took != `RAM_LAT + 1)) begin
      $display("data access at 0x%08h took %0d cycles from idle, expected %0d",
               daddr, took, `RAM_LAT + 1);
      protoErrors++;
    end
    dataActive = 1'b0;
    lastDone = cyc;
    dataDone++;
  endtask

  // fetch completion, sees every earlier data write
  task automatic finishInst;
    logic expFault;
    int idx;
    int took;
    if (!iREN) begin
      $display("instruction wait dropped with no fetch at cycle %0d", cyc);
      protoErrors++;
      return;
    end
    if (dReq) begin
      $display("fetch completed ahead of a pending data request at cycle %0d", cyc);
      protoErrors++;
    end
    expFault = badAddress(iaddr);
    idx = int'(iaddr >> 2);
    took = cyc - instStart + 1;
    if (iFault !== expFault) begin
      $display("FAILED iFault at 0x%08h: expected 0x%0h, actual 0x%0h", iaddr, expFault, iFault);
      instErrors++;
    end else if (!expFault && (iload !== model[idx])) begin
      $display("FAILED iload at 0x%08h: expected 0x%08h, actual 0x%08h",
               iaddr, model[idx], iload);
      instErrors++;
    end
    if (instTimed && (took != `RAM_LAT + 1)) begin
      $display("fetch at 0x%08h took %0d cycles from idle, expected %0d",
               iaddr, took, `RAM_LAT + 1);
      protoErrors++;
    end
    instActive = 1'b0;
    lastDone = cyc;
    instDone++;
  endtask

  always @(posedge CLK) begin
    cyc = cyc + 1;
    dReq = dREN | dWEN;
    if (rst) begin
      // bus stays quiet through reset
      if (!iwait || !dwait || iFault || dFault) begin
        $display("waits low or faults high during reset at cycle %0d", cyc);
        protoErrors++;
      end
      dataActive = 1'b0;
      instActive = 1'b0;
    end else begin
      // the cycle right after a completion is the RAM rest cycle, not idle
      if (dReq && !dataActive) begin
        dataActive = 1'b1;
        dataStart = cyc;
        dataTimed = (cyc >= lastDone + 2) && !iREN;
      end
      if (iREN && !instActive) begin
        instActive = 1'b1;
        instStart = cyc;
        instTimed = (cyc >= lastDone + 2) && !dReq;
      end
      if (dReq) begin
        instTimed = 1'b0;
      end
      if (!iwait && !dwait) begin
        $display("iwait and dwait low together at cycle %0d", cyc);
        protoErrors++;
      end
      if ((iwait && iFault) || (dwait && dFault)) begin
        $display("fault flag high without a completion at cycle %0d", cyc);
        protoErrors++;
      end
      if (!dwait) begin
        finishData();
      end
      if (!iwait) begin
        finishInst();
      end
    end
  end

endmodule

`default_nettype wire

// File: verif/memorySystemTb.sv
// testbench top, random fetch and data requestors on the memory system with a checker attached
`timescale 1ns/10ps
`default_nettype none

`include "memCtrl_macros.svh"

module memorySystemTb import cpuTypesPkg::*; ();

  localparam int NREQ = 400;
  localparam int TIMEOUT = NREQ * 2 * (`RAM_LAT + 2) * 4;
  localparam logic [31:0] SEED = 32'h5228_f060;

  logic  CLK;
  logic  rst;
  logic  iREN;
  logic  dREN;
  logic  dWEN;
  word_t iaddr;
  word_t daddr;
  word_t dstore;
  logic  iwait;
  logic  dwait;
  logic  iFault;
  logic  dFault;
  word_t iload;
  word_t dload;

  int dataErrors;
  int instErrors;
  int protoErrors;
  int dataDone;
  int instDone;
  int countErrors;
  int cycles;

  // separate streams so the two requestors never race on one state
  word_t dataRng;
  word_t instRng;

  memorySystem memorySystem_i (
    .CLK(CLK), .rst(rst),
    .iREN(iREN), .iaddr(iaddr), .iwait(iwait), .iload(iload), .iFault(iFault),
    .dREN(dREN), .dWEN(dWEN), .daddr(daddr), .dstore(dstore),
    .dwait(dwait), .dload(dload), .dFault(dFault)
  );

  memorySystemChecker memorySystemChecker_i (
    .CLK(CLK), .rst(rst),
    .iREN(iREN), .iaddr(iaddr), .iwait(iwait), .iload(iload), .iFault(iFault),
    .dREN(dREN), .dWEN(dWEN), .daddr(daddr), .dstore(dstore),
    .dwait(dwait), .dload(dload), .dFault(dFault),
    .dataErrors(dataErrors), .instErrors(instErrors), .protoErrors(protoErrors),
    .dataDone(dataDone), .instDone(instDone)
  );

  function automatic word_t nextRandom(input word_t s);
    word_t x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // low and high ends of the RAM, so reads often hit earlier writes
  // roughly one in sixteen misaligned or past the end
  function automatic word_t makeAddress(input word_t r);
    word_t idx;
    idx = {26'd0, r[13:8]};
    if (r[31]) begin
      idx = word_t'(`RAM_WORDS - 1) - idx;
    end
    if (r[7:4] == 4'hF) begin
      if (r[16]) begin
        return (word_t'(`RAM_WORDS) + {24'd0, r[23:16]}) << 2;
      end
      return (idx << 2) | {30'd0, r[17], 1'b1};
    end
    return idx << 2;
  endfunction

  // data requestor, gaps of 0 to 7 cycles leave room for fetches
  task automatic runData;
    word_t r;
    for (int n = 0; n < NREQ; n++) begin
      dataRng = nextRandom(dataRng);
      r = dataRng;
      #1;
      if (r[2:0] != 3'd0) begin
        dREN = 1'b0;
        dWEN = 1'b0;
        repeat (int'(r[2:0])) @(posedge CLK);
        #1;
      end
      dWEN = r[3];
      dREN = ~r[3];
      daddr = makeAddress(r);
      dataRng = nextRandom(dataRng);
      dstore = dataRng;
      // held until dwait is low on an edge
      @(posedge CLK);
      while (dwait) @(posedge CLK);
    end
    #1;
    dREN = 1'b0;
    dWEN = 1'b0;
  endtask

  // fetch requestor, starved while the data side stays busy
  task automatic runInst;
    word_t r;
    for (int n = 0; n < NREQ; n++) begin
      instRng = nextRandom(instRng);
      r = instRng;
      #1;
      if (r[1:0] != 2'd0) begin
        iREN = 1'b0;
        repeat (int'(r[1:0])) @(posedge CLK);
        #1;
      end
      iREN = 1'b1;
      iaddr = makeAddress(r);
      @(posedge CLK);
      while (iwait) @(posedge CLK);
    end
    #1;
    iREN = 1'b0;
  endtask

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // run limit from the request count and the worst access length
  initial begin
    cycles = 0;
    while (cycles < TIMEOUT) begin
      @(posedge CLK);
      cycles++;
    end
    $display("timeout: requests still outstanding after %0d cycles", cycles);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    rst = 1'b1;
    iREN = 1'b0;
    dREN = 1'b0;
    dWEN = 1'b0;
    iaddr = '0;
    daddr = '0;
    dstore = '0;
    countErrors = 0;
    dataRng = SEED;
    instRng = nextRandom(SEED);
    repeat (10) @(posedge CLK);
    #1;
    rst = 1'b0;
    @(posedge CLK);
    fork
      runInst();
      runData();
    join
    @(posedge CLK);
    if ((dataDone != NREQ) || (instDone != NREQ)) begin
      $display("completion count wrong: data %0d, instruction %0d, expected %0d each",
               dataDone, instDone, NREQ);
      countErrors = 1;
    end
    $display("errors: data %0d, instruction %0d, protocol %0d, count %0d",
             dataErrors, instErrors, protoErrors, countErrors);
    if (dataErrors + instErrors + protoErrors + countErrors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+include
logic/cpuTypesPkg.sv
logic/ramModel.sv
logic/memoryControl.sv
logic/memorySystem.sv
verif/memorySystemChecker.sv
verif/memorySystemTb.sv

// File: Makefile
# Verilator build, run, lint and clean for the memory system testbench

TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := memorySystemTb
RTL_TOP  := memorySystem
FILELIST := list.f
BUILD    := obj_dir
LOG      := sim.log

SOURCES  := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# the log decides the result, tee hides the exit status
run: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG) || { echo "simulation did not complete"; exit 1; }

lint:
	$(TOOL) --lint-only -Wall --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
